// ==== compile.f ====
+incdir+design
+incdir+verif
design/mipsPkg.sv
design/instrDecoder.sv
design/regFile.sv
design/hazardUnit.sv
design/executeUnit.sv
design/fetchStage.sv
design/datapath.sv
design/mipsCore.sv
verif/tbMipsCore.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core testbench, pass is the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tbMipsCore -f compile.f \
	-o simMipsCore > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/simMipsCore > sim.log 2>&1 || echo "simulator returned an error status"
grep -qx "RESULT: PASS" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// ==== verif/tbProgram.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// instruction encoders
function automatic logic [31:0] encR(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
		logic [4:0] rd, logic [4:0] sh);
	return {`OP_RTYPE, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] encI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] sext16(logic [15:0] v);
	return {{16{v[15]}}, v};
endfunction

task automatic emit(logic [31:0] word);
	rowT row;
	row = '0;
	row.instr = word;
	progTable.push_back(row);
endtask

// store of rt, expected ones get the next free offset
task automatic emitStore(logic [4:0] rt, logic expected);
	rowT row;
	logic [15:0] off;
	if (expected) begin
		off = nextOff;
		nextOff = nextOff + 16'd4;
	end else begin
		off = skipOff;
		skipOff = skipOff + 16'd4;
	end
	row.instr = encI(`OP_SW, 5'd0, rt, off);
	row.stores = expected;
	row.addr = {16'd0, off};
	row.data = model[rt];
	progTable.push_back(row);
endtask

task automatic buildProgram();
	logic [15:0] immA;
	logic [15:0] immB;
	logic [15:0] immC;
	logic [15:0] immD;
	logic [15:0] immE;
	logic [15:0] immF;
	logic [15:0] shBits;
	logic [15:0] loadOff;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [63:0] prodS;
	logic [63:0] prodU;
	int          target;
	lcgState = 32'd19390;
	nextOff = 16'h0000;
	skipOff = 16'h0600;
	for (int r = 0; r < 32; r++) begin
		model[r] = '0;
	end
	immA = randomHalf();
	immB = randomHalf();
	immC = randomHalf();
	immD = randomHalf();
	immE = randomHalf();
	immF = randomHalf();
	shBits = randomHalf();

	//////////////////////////////////////////////////////////////////////
	// dependent ALU chain
	//////////////////////////////////////////////////////////////////////
	emit(encI(`OP_ADDI, 5'd0, 5'd1, immA));
	model[1] = sext16(immA);
	emit(encI(`OP_ADDI, 5'd1, 5'd2, immB));
	model[2] = model[1] + sext16(immB);
	emit(encR(`FN_ADD, 5'd1, 5'd2, 5'd3, 5'd0));
	model[3] = model[1] + model[2];
	emit(encR(`FN_SUB, 5'd3, 5'd1, 5'd4, 5'd0));
	model[4] = model[3] - model[1];
	emit(encR(`FN_AND, 5'd4, 5'd3, 5'd5, 5'd0));
	model[5] = model[4] & model[3];
	emit(encR(`FN_OR, 5'd5, 5'd1, 5'd6, 5'd0));
	model[6] = model[5] | model[1];
	emit(encR(`FN_SLT, 5'd6, 5'd4, 5'd7, 5'd0));
	model[7] = ($signed(model[6]) < $signed(model[4])) ? 32'd1 : 32'd0;
	emit(encR(`FN_SLL, 5'd0, 5'd6, 5'd8, shBits[4:0]));
	model[8] = model[6] << shBits[4:0];
	emit(encI(`OP_LUI, 5'd0, 5'd9, immC));
	model[9] = {immC, 16'd0};
	emit(encI(`OP_ORI, 5'd9, 5'd9, immD));
	model[9] = model[9] | {16'd0, immD};
	emit(encI(`OP_ANDI, 5'd9, 5'd10, immE));
	model[10] = model[9] & {16'd0, immE};
	emit(encI(`OP_SLTI, 5'd10, 5'd11, immF));
	model[11] = ($signed(model[10]) < $signed(sext16(immF))) ? 32'd1 : 32'd0;
	// r8 lands three slots into this run
	loadOff = nextOff + 16'd12;
	for (int r = 11; r >= 2; r--) begin
		emitStore(5'(r), 1'b1);
	end

	// load-use
	emit(encI(`OP_LW, 5'd0, 5'd12, loadOff));
	model[12] = model[8];
	emit(encR(`FN_ADD, 5'd12, 5'd2, 5'd13, 5'd0));
	model[13] = model[12] + model[2];
	emitStore(5'd13, 1'b1);

	//////////////////////////////////////////////////////////////////////
	// control flow
	//////////////////////////////////////////////////////////////////////
	emit(encI(`OP_BEQ, 5'd1, 5'd1, 16'd1));
	emitStore(5'd3, 1'b0);
	emit(encI(`OP_BNE, 5'd1, 5'd1, 16'd1));
	emitStore(5'd4, 1'b1);
	target = progTable.size() + 2;
	emit({`OP_J, 26'(target)});
	emitStore(5'd5, 1'b0);
	emitStore(5'd6, 1'b1);
	// branch on a value still in execute
	emit(encI(`OP_ADDI, 5'd0, 5'd22, 16'd7));
	model[22] = 32'd7;
	emit(encI(`OP_BNE, 5'd22, 5'd0, 16'd1));
	emitStore(5'd7, 1'b0);
	emitStore(5'd22, 1'b1);

	//////////////////////////////////////////////////////////////////////
	// multiply and hi/lo moves
	//////////////////////////////////////////////////////////////////////
	opA = nextRandom();
	opB = nextRandom();
	emit(encI(`OP_LUI, 5'd0, 5'd14, opA[31:16]));
	emit(encI(`OP_ORI, 5'd14, 5'd14, opA[15:0]));
	emit(encI(`OP_LUI, 5'd0, 5'd15, opB[31:16]));
	emit(encI(`OP_ORI, 5'd15, 5'd15, opB[15:0]));
	model[14] = opA;
	model[15] = opB;
	prodS = longint'($signed(opA)) * longint'($signed(opB));
	prodU = {32'd0, opA} * {32'd0, opB};
	emit(encR(`FN_MULT, 5'd14, 5'd15, 5'd0, 5'd0));
	emit(encR(`FN_MFHI, 5'd0, 5'd0, 5'd16, 5'd0));
	emit(encR(`FN_MFLO, 5'd0, 5'd0, 5'd17, 5'd0));
	model[16] = prodS[63:32];
	model[17] = prodS[31:0];
	emitStore(5'd16, 1'b1);
	emitStore(5'd17, 1'b1);
	emit(encR(`FN_MULTU, 5'd14, 5'd15, 5'd0, 5'd0));
	emit(encR(`FN_MFHI, 5'd0, 5'd0, 5'd18, 5'd0));
	emit(encR(`FN_MFLO, 5'd0, 5'd0, 5'd19, 5'd0));
	model[18] = prodU[63:32];
	model[19] = prodU[31:0];
	emitStore(5'd18, 1'b1);
	emitStore(5'd19, 1'b1);
	emit(encR(`FN_MTHI, 5'd1, 5'd0, 5'd0, 5'd0));
	emit(encR(`FN_MTLO, 5'd2, 5'd0, 5'd0, 5'd0));
	emit(encR(`FN_MFHI, 5'd0, 5'd0, 5'd20, 5'd0));
	emit(encR(`FN_MFLO, 5'd0, 5'd0, 5'd21, 5'd0));
	model[20] = model[1];
	model[21] = model[2];
	emitStore(5'd20, 1'b1);
	emitStore(5'd21, 1'b1);

	// park on a jump to itself
	target = progTable.size();
	emit({`OP_J, 26'(target)});

	storesExpected = 0;
	foreach (progTable[k]) begin
		if (progTable[k].stores) begin
			storesExpected++;
		end
	end
endtask

`endif

// ==== verif/tbMipsCore.sv ====
`include "mips_params.svh"

module tbMipsCore;

	typedef struct packed {
		logic [31:0] instr;
		logic        stores;
		logic [31:0] addr;
		logic [31:0] data;
	} rowT;

	logic        clk;
	logic        rstN;
	logic [31:0] pcF;
	logic [31:0] instrF;
	logic        memWrite;
	logic [31:0] dataAddr;
	logic [31:0] writeData;
	logic [31:0] readData;

	logic [31:0] rom [512];
	logic [31:0] ram [512];

	rowT         progTable [$];
	logic [31:0] model [32];
	logic [31:0] lcgState;
	logic [15:0] nextOff;
	logic [15:0] skipOff;
	int          programLen;
	int          storesExpected;
	int          storesSeen;
	int          valueErrors;
	int          extraStores;

	mipsCore dut0 (
		.clk      (clk),
		.rstN     (rstN),
		.pcF      (pcF),
		.instrF   (instrF),
		.memWrite (memWrite),
		.dataAddr (dataAddr),
		.writeData(writeData),
		.readData (readData)
	);

	always #4 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// memories, both read combinationally
	//////////////////////////////////////////////////////////////////////
	assign instrF = rom[pcF[10:2]];
	assign readData = ram[dataAddr[10:2]];

	always @(posedge clk) begin
		if (memWrite) begin
			ram[dataAddr[10:2]] <= writeData;
		end
	end

	`include "tbProgram.svh"

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	function automatic logic [15:0] randomHalf();
		logic [31:0] v;
		v = nextRandom();
		return v[30:15];
	endfunction

	task automatic waitStore();
		do begin
			@(negedge clk);
		end while (!memWrite);
	endtask

	task automatic checkStore(int k);
		rowT row;
		row = progTable[k];
		storesSeen++;
		if (dataAddr !== row.addr) begin
			$display("[FAIL] %0t: store %0d (row %0d) address %h, expected %h",
				$time, storesSeen, k, dataAddr, row.addr);
			valueErrors++;
		end
		if (writeData !== row.data) begin
			$display("[FAIL] %0t: store %0d (row %0d) data %h, expected %h",
				$time, storesSeen, k, writeData, row.data);
			valueErrors++;
		end
	endtask

	task automatic printCounts();
		$display("stores seen %0d of %0d, value errors %0d, unexpected stores %0d",
			storesSeen, storesExpected, valueErrors, extraStores);
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		storesSeen = 0;
		valueErrors = 0;
		extraStores = 0;
		buildProgram();
		for (int i = 0; i < 512; i++) begin
			if (i < progTable.size()) begin
				rom[i] = progTable[i].instr;
			end else begin
				rom[i] = 32'd0;
			end
			// background differs per word
			ram[i] = 32'hD00D_0000 ^ (i * 32'h0001_0003);
		end
		programLen = progTable.size();

		repeat (2) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		if (pcF !== `MIPS_RESET_PC) begin
			$display("[FAIL] %0t: pcF %h after reset, expected %h",
				$time, pcF, `MIPS_RESET_PC);
			valueErrors++;
		end
		if (memWrite !== 1'b0) begin
			$display("[FAIL] %0t: memWrite high right after reset", $time);
			valueErrors++;
		end

		// each store pulse pairs with the next storing row
		for (int k = 0; k < programLen; k++) begin
			if (progTable[k].stores) begin
				waitStore();
				checkStore(k);
			end
		end

		// program now spins on its last jump
		repeat (8) begin
			@(negedge clk);
			if (memWrite) begin
				$display("store to %h after the last expected store", dataAddr);
				extraStores++;
			end
		end

		printCounts();
		if (valueErrors == 0 && extraStores == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (programLen > 0);
		repeat (programLen * 20) @(posedge clk);
		$display("timeout after %0d cycles, stores were missing", programLen * 20);
		printCounts();
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== design/mipsCore.sv ====
module mipsCore (
	input  logic        clk,
	input  logic        rstN,
	output logic [31:0] pcF,
	input  logic [31:0] instrF,
	output logic        memWrite,
	output logic [31:0] dataAddr,
	output logic [31:0] writeData,
	input  logic [31:0] readData
);

	mipsPkg::instrT  instrD;
	mipsPkg::fwdSelT fwdAE;
	mipsPkg::fwdSelT fwdBE;
	logic [31:0]     pcPlus4D;
	logic [31:0]     branchTargetD;
	logic [31:0]     jumpTargetD;
	logic            pcSrcD;
	logic            jumpD;
	logic            stallF;
	logic            stallD;
	logic            flushE;
	logic            fwdAD;
	logic            fwdBD;
	logic            branchD;
	logic [4:0]      rsD;
	logic [4:0]      rtD;
	logic [4:0]      rsE;
	logic [4:0]      rtE;
	logic [4:0]      writeRegE;
	logic [4:0]      writeRegM;
	logic [4:0]      writeRegW;
	logic            regWriteE;
	logic            regWriteM;
	logic            regWriteW;
	logic            memToRegE;
	logic            memToRegM;

	fetchStage fetch0 (
		.clk          (clk),
		.rstN         (rstN),
		.stallF       (stallF),
		.stallD       (stallD),
		.pcSrcD       (pcSrcD),
		.jumpD        (jumpD),
		.branchTargetD(branchTargetD),
		.jumpTargetD  (jumpTargetD),
		.pcF          (pcF),
		.instrF       (instrF),
		.instrD       (instrD),
		.pcPlus4D     (pcPlus4D)
	);

	datapath dp0 (
		.clk          (clk),
		.rstN         (rstN),
		.instrD       (instrD),
		.pcPlus4D     (pcPlus4D),
		.pcSrcD       (pcSrcD),
		.jumpD        (jumpD),
		.branchTargetD(branchTargetD),
		.jumpTargetD  (jumpTargetD),
		.rsD          (rsD),
		.rtD          (rtD),
		.branchD      (branchD),
		.rsE          (rsE),
		.rtE          (rtE),
		.writeRegE    (writeRegE),
		.regWriteE    (regWriteE),
		.memToRegE    (memToRegE),
		.writeRegM    (writeRegM),
		.regWriteM    (regWriteM),
		.memToRegM    (memToRegM),
		.writeRegW    (writeRegW),
		.regWriteW    (regWriteW),
		.stallD       (stallD),
		.flushE       (flushE),
		.fwdAD        (fwdAD),
		.fwdBD        (fwdBD),
		.fwdAE        (fwdAE),
		.fwdBE        (fwdBE),
		.memWrite     (memWrite),
		.dataAddr     (dataAddr),
		.writeData    (writeData),
		.readData     (readData)
	);

	hazardUnit hz0 (
		.rsD      (rsD),
		.rtD      (rtD),
		.branchD  (branchD),
		.rsE      (rsE),
		.rtE      (rtE),
		.writeRegE(writeRegE),
		.regWriteE(regWriteE),
		.memToRegE(memToRegE),
		.writeRegM(writeRegM),
		.regWriteM(regWriteM),
		.memToRegM(memToRegM),
		.writeRegW(writeRegW),
		.regWriteW(regWriteW),
		.stallF   (stallF),
		.stallD   (stallD),
		.flushE   (flushE),
		.fwdAD    (fwdAD),
		.fwdBD    (fwdBD),
		.fwdAE    (fwdAE),
		.fwdBE    (fwdBE)
	);

endmodule

// ==== design/datapath.sv ====
module datapath (
	input  logic            clk,
	input  logic            rstN,
	input  mipsPkg::instrT  instrD,
	input  logic [31:0]     pcPlus4D,
	output logic            pcSrcD,
	output logic            jumpD,
	output logic [31:0]     branchTargetD,
	output logic [31:0]     jumpTargetD,
	// hazard unit
	output logic [4:0]      rsD,
	output logic [4:0]      rtD,
	output logic            branchD,
	output logic [4:0]      rsE,
	output logic [4:0]      rtE,
	output logic [4:0]      writeRegE,
	output logic            regWriteE,
	output logic            memToRegE,
	output logic [4:0]      writeRegM,
	output logic            regWriteM,
	output logic            memToRegM,
	output logic [4:0]      writeRegW,
	output logic            regWriteW,
	input  logic            stallD,
	input  logic            flushE,
	input  logic            fwdAD,
	input  logic            fwdBD,
	input  mipsPkg::fwdSelT fwdAE,
	input  mipsPkg::fwdSelT fwdBE,
	// data memory
	output logic            memWrite,
	output logic [31:0]     dataAddr,
	output logic [31:0]     writeData,
	input  logic [31:0]     readData
);

	mipsPkg::ctrlT  ctrlD;
	mipsPkg::idExT  idExNext;
	mipsPkg::idExT  idEx;
	mipsPkg::exMemT exMemNext;
	mipsPkg::exMemT exMem;
	mipsPkg::memWbT memWbNext;
	mipsPkg::memWbT memWb;

	logic [31:0] rdA;
	logic [31:0] rdB;
	logic [31:0] srcAD;
	logic [31:0] srcBD;
	logic [31:0] immD;
	logic [31:0] srcAE;
	logic [31:0] srcBE;
	logic [31:0] aluOutE;
	logic [31:0] hiE;
	logic [31:0] loE;
	logic [31:0] resultW;

	//////////////////////////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////////////////////////
	instrDecoder dec0 (
		.instr(instrD),
		.ctrl (ctrlD)
	);

	assign rsD = instrD.r.rs;
	assign rtD = instrD.r.rt;

	regFile rf0 (
		.clk    (clk),
		.rstN   (rstN),
		.writeEn(memWb.regWrite),
		.raddrA (rsD),
		.raddrB (rtD),
		.waddr  (memWb.writeReg),
		.wdata  (resultW),
		.rdataA (rdA),
		.rdataB (rdB)
	);

	assign immD = ctrlD.zeroExt ? {16'd0, instrD.i.imm16} :
		{{16{instrD.i.imm16[15]}}, instrD.i.imm16};

	// branch compare takes the EX/MEM result when it is newer
	assign srcAD = fwdAD ? exMem.aluOut : rdA;
	assign srcBD = fwdBD ? exMem.aluOut : rdB;

	assign branchD = ctrlD.branch;
	assign pcSrcD = ctrlD.branch & ((srcAD == srcBD) ^ ctrlD.branchNe);
	assign branchTargetD = pcPlus4D + {immD[29:0], 2'b00};
	assign jumpD = ctrlD.jump;
	assign jumpTargetD = {pcPlus4D[31:28], instrD.j.target26, 2'b00};

	always_comb begin
		idExNext.ctrl = ctrlD;
		idExNext.srcA = rdA;
		idExNext.srcB = rdB;
		idExNext.imm = immD;
		idExNext.shamt = instrD.r.shamt;
		idExNext.rs = instrD.r.rs;
		idExNext.rt = instrD.r.rt;
		idExNext.writeReg = ctrlD.regDst ? instrD.r.rd : instrD.r.rt;
	end

	// a held decode stage sends a bubble on
	always_ff @(posedge clk) begin
		if (!rstN || flushE || stallD) begin
			idEx <= '0;
		end else begin
			idEx <= idExNext;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// execute
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (fwdAE)
			mipsPkg::fwdFromMem: srcAE = exMem.aluOut;
			mipsPkg::fwdFromWb:  srcAE = resultW;
			default:             srcAE = idEx.srcA;
		endcase
		case (fwdBE)
			mipsPkg::fwdFromMem: srcBE = exMem.aluOut;
			mipsPkg::fwdFromWb:  srcBE = resultW;
			default:             srcBE = idEx.srcB;
		endcase
	end

	executeUnit eu0 (
		.clk   (clk),
		.rstN  (rstN),
		.ctrl  (idEx.ctrl),
		.srcA  (srcAE),
		.srcB  (srcBE),
		.imm   (idEx.imm),
		.shamt (idEx.shamt),
		.aluOut(aluOutE),
		.hi    (hiE),
		.lo    (loE)
	);

	assign rsE = idEx.rs;
	assign rtE = idEx.rt;
	assign writeRegE = idEx.writeReg;
	assign regWriteE = idEx.ctrl.regWrite;
	assign memToRegE = (idEx.ctrl.resSrc == mipsPkg::resMem);

	always_comb begin
		exMemNext.regWrite = idEx.ctrl.regWrite;
		exMemNext.memWrite = idEx.ctrl.memWrite;
		exMemNext.resSrc = idEx.ctrl.resSrc;
		exMemNext.aluOut = aluOutE;
		exMemNext.writeData = srcBE;
		exMemNext.writeReg = idEx.writeReg;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			exMem <= '0;
		end else begin
			exMem <= exMemNext;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// memory and writeback
	//////////////////////////////////////////////////////////////////////
	assign memWrite = exMem.memWrite;
	assign dataAddr = exMem.aluOut;
	assign writeData = exMem.writeData;
	assign writeRegM = exMem.writeReg;
	assign regWriteM = exMem.regWrite;
	assign memToRegM = (exMem.resSrc == mipsPkg::resMem);

	// hi/lo cannot change between an mfhi's execute and memory cycles
	always_comb begin
		memWbNext.regWrite = exMem.regWrite;
		memWbNext.resSrc = exMem.resSrc;
		memWbNext.aluOut = exMem.aluOut;
		memWbNext.readData = readData;
		memWbNext.hi = hiE;
		memWbNext.lo = loE;
		memWbNext.writeReg = exMem.writeReg;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			memWb <= '0;
		end else begin
			memWb <= memWbNext;
		end
	end

	always_comb begin
		case (memWb.resSrc)
			mipsPkg::resMem: resultW = memWb.readData;
			mipsPkg::resHi:  resultW = memWb.hi;
			mipsPkg::resLo:  resultW = memWb.lo;
			default:         resultW = memWb.aluOut;
		endcase
	end

	assign writeRegW = memWb.writeReg;
	assign regWriteW = memWb.regWrite;

endmodule

// ==== design/fetchStage.sv ====
`include "mips_params.svh"

module fetchStage (
	input  logic           clk,
	input  logic           rstN,
	input  logic           stallF,
	input  logic           stallD,
	input  logic           pcSrcD,
	input  logic           jumpD,
	input  logic [31:0]    branchTargetD,
	input  logic [31:0]    jumpTargetD,
	output logic [31:0]    pcF,
	input  logic [31:0]    instrF,
	output mipsPkg::instrT instrD,
	output logic [31:0]    pcPlus4D
);

	logic [31:0] pcPlus4F;
	logic [31:0] pcNext;

	assign pcPlus4F = pcF + 32'd4;

	// decode redirects win over sequential fetch
	always_comb begin
		if (jumpD) begin
			pcNext = jumpTargetD;
		end else if (pcSrcD) begin
			pcNext = branchTargetD;
		end else begin
			pcNext = pcPlus4F;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pcF <= `MIPS_RESET_PC;
		end else if (!stallF) begin
			pcF <= pcNext;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// IF/ID register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			instrD <= '0;
			pcPlus4D <= '0;
		end else if (!stallD) begin
			// no delay slot, so the word behind a redirect becomes a nop
			if (pcSrcD || jumpD) begin
				instrD <= '0;
			end else begin
				instrD <= instrF;
			end
			pcPlus4D <= pcPlus4F;
		end
	end

endmodule

// ==== design/executeUnit.sv ====
module executeUnit (
	input  logic          clk,
	input  logic          rstN,
	input  mipsPkg::ctrlT ctrl,
	input  logic [31:0]   srcA,
	input  logic [31:0]   srcB,
	input  logic [31:0]   imm,
	input  logic [4:0]    shamt,
	output logic [31:0]   aluOut,
	output logic [31:0]   hi,
	output logic [31:0]   lo
);

	logic [31:0] opB;
	logic [31:0] aluRes;
	logic [63:0] mulA;
	logic [63:0] mulB;
	logic [63:0] product;

	assign opB = ctrl.aluSrcImm ? imm : srcB;

	always_comb begin
		case (ctrl.aluOp)
			mipsPkg::aluAdd:   aluRes = srcA + opB;
			mipsPkg::aluSub:   aluRes = srcA - opB;
			mipsPkg::aluAnd:   aluRes = srcA & opB;
			mipsPkg::aluOr:    aluRes = srcA | opB;
			mipsPkg::aluSlt:   aluRes = {31'd0, $signed(srcA) < $signed(opB)};
			// sll shifts rt, rs field is zero
			mipsPkg::aluSll:   aluRes = opB << shamt;
			mipsPkg::aluLui:   aluRes = {opB[15:0], 16'd0};
			mipsPkg::aluPassA: aluRes = srcA;
			default:           aluRes = srcA + opB;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// multiplier and hi/lo
	//////////////////////////////////////////////////////////////////////

	// one 64x64 multiply, low 64 bits right for both signednesses
	assign mulA = {{32{ctrl.multSigned & srcA[31]}}, srcA};
	assign mulB = {{32{ctrl.multSigned & srcB[31]}}, srcB};
	assign product = mulA * mulB;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			hi <= '0;
			lo <= '0;
		end else begin
			if (ctrl.writeHi) begin
				hi <= ctrl.mult ? product[63:32] : srcA;
			end
			if (ctrl.writeLo) begin
				lo <= ctrl.mult ? product[31:0] : srcA;
			end
		end
	end

	// mfhi/mflo value rides in aluOut so EX/MEM forwarding sees it
	always_comb begin
		case (ctrl.resSrc)
			mipsPkg::resHi: aluOut = hi;
			mipsPkg::resLo: aluOut = lo;
			default:        aluOut = aluRes;
		endcase
	end

endmodule

// ==== design/hazardUnit.sv ====
module hazardUnit (
	input  logic [4:0]       rsD,
	input  logic [4:0]       rtD,
	input  logic             branchD,
	input  logic [4:0]       rsE,
	input  logic [4:0]       rtE,
	input  logic [4:0]       writeRegE,
	input  logic             regWriteE,
	input  logic             memToRegE,
	input  logic [4:0]       writeRegM,
	input  logic             regWriteM,
	input  logic             memToRegM,
	input  logic [4:0]       writeRegW,
	input  logic             regWriteW,
	output logic             stallF,
	output logic             stallD,
	output logic             flushE,
	output logic             fwdAD,
	output logic             fwdBD,
	output mipsPkg::fwdSelT  fwdAE,
	output mipsPkg::fwdSelT  fwdBE
);

	logic loadUse;
	logic branchWait;

	//////////////////////////////////////////////////////////////////////
	// forwarding
	//////////////////////////////////////////////////////////////////////

	// writeback reaches decode through the register file bypass
	assign fwdAD = regWriteM && (writeRegM != 5'd0) && (writeRegM == rsD);
	assign fwdBD = regWriteM && (writeRegM != 5'd0) && (writeRegM == rtD);

	// EX/MEM is newer than MEM/WB
	always_comb begin
		if (regWriteM && (writeRegM != 5'd0) && (writeRegM == rsE)) begin
			fwdAE = mipsPkg::fwdFromMem;
		end else if (regWriteW && (writeRegW != 5'd0) && (writeRegW == rsE)) begin
			fwdAE = mipsPkg::fwdFromWb;
		end else begin
			fwdAE = mipsPkg::fwdNone;
		end
		if (regWriteM && (writeRegM != 5'd0) && (writeRegM == rtE)) begin
			fwdBE = mipsPkg::fwdFromMem;
		end else if (regWriteW && (writeRegW != 5'd0) && (writeRegW == rtE)) begin
			fwdBE = mipsPkg::fwdFromWb;
		end else begin
			fwdBE = mipsPkg::fwdNone;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stall and flush
	//////////////////////////////////////////////////////////////////////

	// load data is only ready in writeback
	assign loadUse = memToRegE && (writeRegE != 5'd0) &&
		((writeRegE == rsD) || (writeRegE == rtD));

	// branch operands must already sit in EX/MEM as an ALU result
	assign branchWait = branchD && (
		(regWriteE && (writeRegE != 5'd0) && ((writeRegE == rsD) || (writeRegE == rtD))) ||
		(memToRegM && (writeRegM != 5'd0) && ((writeRegM == rsD) || (writeRegM == rtD))));

	assign stallD = loadUse || branchWait;
	assign stallF = stallD;
	assign flushE = stallD;

endmodule

// ==== design/regFile.sv ====
`include "mips_params.svh"

module regFile (
	input  logic        clk,
	input  logic        rstN,
	input  logic        writeEn,
	input  logic [4:0]  raddrA,
	input  logic [4:0]  raddrB,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata,
	output logic [31:0] rdataA,
	output logic [31:0] rdataB
);

	logic [31:0] regs [`MIPS_NREGS];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `MIPS_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	// r0 is hardwired, writeback bypasses the array
	assign rdataA = (raddrA == 5'd0) ? 32'd0 :
		(writeEn && waddr == raddrA) ? wdata : regs[raddrA];
	assign rdataB = (raddrB == 5'd0) ? 32'd0 :
		(writeEn && waddr == raddrB) ? wdata : regs[raddrB];

endmodule

// ==== design/instrDecoder.sv ====
`include "mips_params.svh"

module instrDecoder (
	input  mipsPkg::instrT instr,
	output mipsPkg::ctrlT  ctrl
);

	always_comb begin
		// anything not listed falls out as a no-op
		ctrl = '0;
		ctrl.resSrc = mipsPkg::resAlu;
		ctrl.aluOp = mipsPkg::aluAdd;
		case (instr.i.op)
			`OP_RTYPE: begin
				ctrl.regDst = 1'b1;
				case (instr.r.funct)
					`FN_ADD: begin
						ctrl.regWrite = 1'b1;
						ctrl.aluOp = mipsPkg::aluAdd;
					end
					`FN_SUB: begin
						ctrl.regWrite = 1'b1;
						ctrl.aluOp = mipsPkg::aluSub;
					end
					`FN_AND: begin
						ctrl.regWrite = 1'b1;
						ctrl.aluOp = mipsPkg::aluAnd;
					end
					`FN_OR: begin
						ctrl.regWrite = 1'b1;
						ctrl.aluOp = mipsPkg::aluOr;
					end
					`FN_SLT: begin
						ctrl.regWrite = 1'b1;
						ctrl.aluOp = mipsPkg::aluSlt;
					end
					`FN_SLL: begin
						ctrl.regWrite = 1'b1;
						ctrl.aluOp = mipsPkg::aluSll;
					end
					`FN_MULT, `FN_MULTU: begin
						ctrl.mult = 1'b1;
						ctrl.multSigned = (instr.r.funct == `FN_MULT);
						ctrl.writeHi = 1'b1;
						ctrl.writeLo = 1'b1;
					end
					`FN_MFHI: begin
						ctrl.regWrite = 1'b1;
						ctrl.resSrc = mipsPkg::resHi;
					end
					`FN_MFLO: begin
						ctrl.regWrite = 1'b1;
						ctrl.resSrc = mipsPkg::resLo;
					end
					`FN_MTHI: begin
						ctrl.writeHi = 1'b1;
						ctrl.aluOp = mipsPkg::aluPassA;
					end
					`FN_MTLO: begin
						ctrl.writeLo = 1'b1;
						ctrl.aluOp = mipsPkg::aluPassA;
					end
					default: ctrl.regDst = 1'b0;
				endcase
			end
			`OP_ADDI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			`OP_ANDI, `OP_ORI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.zeroExt = 1'b1;
				ctrl.aluOp = (instr.i.op == `OP_ANDI) ? mipsPkg::aluAnd : mipsPkg::aluOr;
			end
			`OP_SLTI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = mipsPkg::aluSlt;
			end
			`OP_LUI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = mipsPkg::aluLui;
			end
			`OP_LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.resSrc = mipsPkg::resMem;
			end
			`OP_SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			`OP_BEQ: ctrl.branch = 1'b1;
			`OP_BNE: begin
				ctrl.branch = 1'b1;
				ctrl.branchNe = 1'b1;
			end
			`OP_J: ctrl.jump = 1'b1;
			default: ctrl = '0;
		endcase
	end

endmodule

// ==== design/mipsPkg.sv ====
package mipsPkg;

	//////////////////////////////////////////////////////////////////////
	// instruction word views
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rTypeT;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} iTypeT;

	typedef struct packed {
		logic [5:0]  op;
		logic [25:0] target26;
	} jTypeT;

	// same 32 bits, read as R, I or J format
	typedef union packed {
		rTypeT r;
		iTypeT i;
		jTypeT j;
	} instrT;

	//////////////////////////////////////////////////////////////////////
	// control encodings
	//////////////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluSll,
		aluLui,
		aluPassA
	} aluOpT;

	typedef enum logic [1:0] {
		resAlu,
		resMem,
		resHi,
		resLo
	} resSrcT;

	typedef enum logic [1:0] {
		fwdNone,
		fwdFromMem,
		fwdFromWb
	} fwdSelT;

	typedef struct packed {
		logic   regWrite;
		logic   memWrite;
		resSrcT resSrc;
		aluOpT  aluOp;
		logic   aluSrcImm;
		logic   zeroExt;
		logic   regDst;
		logic   branch;
		logic   branchNe;
		logic   jump;
		logic   mult;
		logic   multSigned;
		logic   writeHi;
		logic   writeLo;
	} ctrlT;

	//////////////////////////////////////////////////////////////////////
	// pipeline registers
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		ctrlT        ctrl;
		logic [31:0] srcA;
		logic [31:0] srcB;
		logic [31:0] imm;
		logic [4:0]  shamt;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  writeReg;
	} idExT;

	typedef struct packed {
		logic        regWrite;
		logic        memWrite;
		resSrcT      resSrc;
		logic [31:0] aluOut;
		logic [31:0] writeData;
		logic [4:0]  writeReg;
	} exMemT;

	typedef struct packed {
		logic        regWrite;
		resSrcT      resSrc;
		logic [31:0] aluOut;
		logic [31:0] readData;
		logic [31:0] hi;
		logic [31:0] lo;
		logic [4:0]  writeReg;
	} memWbT;

endpackage

// ==== design/mips_params.svh ====
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// first fetch address and register count
`define MIPS_RESET_PC 32'h0000_0000
`define MIPS_NREGS    32

// primary opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDI  6'h08
`define OP_SLTI  6'h0a
`define OP_ANDI  6'h0c
`define OP_ORI   6'h0d
`define OP_LUI   6'h0f
`define OP_LW    6'h23
`define OP_SW    6'h2b

// funct codes for the special opcode
`define FN_SLL   6'h00
`define FN_MFHI  6'h10
`define FN_MTHI  6'h11
`define FN_MFLO  6'h12
`define FN_MTLO  6'h13
`define FN_MULT  6'h18
`define FN_MULTU 6'h19
`define FN_ADD   6'h20
`define FN_SUB   6'h22
`define FN_AND   6'h24
`define FN_OR    6'h25
`define FN_SLT   6'h2a

`endif
